//--- logic/dct_settings.svh
/* DCT block sizes and word widths
   Shared by the package and every RTL module */
`ifndef DCT_SETTINGS_SVH
`define DCT_SETTINGS_SVH

// Block geometry
`define DCT_N     8    // Points per transform, rows per block

// Word widths
`define DCT_DW    8    // Input sample, level shifted
`define DCT_CW    11   // Coefficient after the row pass
`define DCT_QW    12   // Coefficient after the column pass

// Cosine table scaling
`define DCT_FRAC  6    // Fraction bits of the integer cosine weights

`endif

//--- logic/dct_pkg.sv
/* DCT package
   Sample and coefficient types, integer cosine table, JPEG zigzag order */
`default_nettype none
`include "dct_settings.svh"

package dct_pkg;

    // ------------------------------
    // Data types
    // ------------------------------
    typedef logic signed [`DCT_DW-1:0] sample_t;   // Level-shifted input, -128..127
    typedef logic signed [`DCT_CW-1:0] coef1_t;    // Row pass result
    typedef logic signed [`DCT_QW-1:0] coef_t;     // Final coefficient
    typedef logic [2:0]                row_idx_t;  // Row or column in a block
    typedef logic [4:0]                pair_idx_t; // Output pair in a block

    // ------------------------------
    // Cosine weights
    // ------------------------------
    // Row k, column n: round(64 * c(k) * cos((2n+1)k*pi/16))
    // c(0) = 1/(2*sqrt(2)), c(k>0) = 1/2
    localparam logic signed [7:0] dct_cos [0:7][0:7] = '{
        '{ 23,  23,  23,  23,  23,  23,  23,  23},  // DC
        '{ 31,  27,  18,   6,  -6, -18, -27, -31},
        '{ 30,  12, -12, -30, -30, -12,  12,  30},
        '{ 27,  -6, -31, -18,  18,  31,   6, -27},
        '{ 23, -23, -23,  23,  23, -23, -23,  23},
        '{ 18, -31,   6,  27, -27,  -6,  31, -18},
        '{ 12, -30,  30, -12, -12,  30, -30,  12},
        '{  6, -18,  27, -31,  31, -27,  18,  -6}   // Highest frequency
    };

    // ------------------------------
    // Zigzag scan
    // ------------------------------
    // Entry i is the raster position (row*8 + column) of zigzag position i
    // Row is vertical frequency, column horizontal
    localparam logic [5:0] zz_order [0:63] = '{
         0,  1,  8, 16,  9,  2,  3, 10,
        17, 24, 32, 25, 18, 11,  4,  5,
        12, 19, 26, 33, 40, 48, 41, 34,
        27, 20, 13,  6,  7, 14, 21, 28,
        35, 42, 49, 56, 57, 50, 43, 36,
        29, 22, 15, 23, 30, 37, 44, 51,
        58, 59, 52, 45, 38, 31, 39, 46,
        53, 60, 61, 54, 47, 55, 62, 63
    };

endpackage

`default_nettype wire

//--- logic/dct_1d.sv
/* 8-point 1-D DCT
   Direct sums of products against the cosine table, rounded and saturated,
   registered with the row count behind a valid/hold handshake */
`default_nettype none
`include "dct_settings.svh"

module dct_1d #(
    parameter int IW = `DCT_DW,   // Input width
    parameter int OW = `DCT_CW    // Output width
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire logic signed [IW-1:0] di [`DCT_N-1:0],
    input  wire                       di_valid,
    output logic                      di_hold,
    input  wire dct_pkg::row_idx_t    di_cnt,
    output logic signed [OW-1:0]      q [`DCT_N-1:0],
    output logic                      q_valid,
    input  wire                       q_hold,
    output dct_pkg::row_idx_t         q_cnt
);
    import dct_pkg::*;

    localparam int SW = IW + 11;  // Eight products of IW x 8 bits
    localparam logic signed [SW-1:0] SAT_HI = SW'(2 ** (OW - 1) - 1);
    localparam logic signed [SW-1:0] SAT_LO = ~SAT_HI;                // -2^(OW-1)
    localparam logic signed [SW-1:0] RND    = SW'(1 << (`DCT_FRAC - 1)); // Half LSB

    logic signed [SW-1:0] acc [`DCT_N-1:0];   // Raw sums
    logic signed [SW-1:0] rnd [`DCT_N-1:0];   // Rounded, scaled back
    logic signed [OW-1:0] sat [`DCT_N-1:0];   // Clipped to output width
    logic                 load;

    // ------------------------------
    // Datapath
    // ------------------------------
    always_comb begin
        for (int k = 0; k < `DCT_N; k++) begin
            acc[k] = '0;
            for (int n = 0; n < `DCT_N; n++) begin
                acc[k] = acc[k] + SW'(dct_cos[k][n]) * SW'(di[n]);  // Sign extended
            end
        end
    end

    always_comb begin
        for (int k = 0; k < `DCT_N; k++) begin
            rnd[k] = (acc[k] + RND) >>> `DCT_FRAC;  // Round half up
            if (rnd[k] > SAT_HI) begin
                sat[k] = OW'(SAT_HI);
            end else if (rnd[k] < SAT_LO) begin
                sat[k] = OW'(SAT_LO);
            end else begin
                sat[k] = OW'(rnd[k]);
            end
        end
    end

    // ------------------------------
    // Output register
    // ------------------------------
    assign di_hold = q_valid && q_hold;   // Full and not drained
    assign load    = di_valid && !di_hold;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_valid <= 1'b0;
            q_cnt   <= '0;
        end else begin
            if (!di_hold) begin
                q_valid <= di_valid;  // Empty or being drained
            end
            if (load) begin
                q_cnt <= di_cnt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            q <= sat;
        end
    end

endmodule

`default_nettype wire

//--- logic/pingpong_ctrl.sv
/* Ping-pong bank control
   Counts filled banks and steers write bank, read bank and back-pressure */
`default_nettype none

module pingpong_ctrl (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  wr_done,    // Last row of a block written
    input  wire  rd_done,    // Last read of a block taken
    output logic wr_bank,
    output logic rd_bank,
    output logic rd_ready,   // A filled bank is waiting
    output logic full        // Both banks filled
);
    typedef enum logic [1:0] {
        EMPTY = 2'd0,
        ONE   = 2'd1,
        TWO   = 2'd2
    } fill_t;

    fill_t state;
    fill_t state_nxt;

    // Fill count
    always_comb begin
        state_nxt = state;
        case (state)
            EMPTY: begin
                if (wr_done) begin
                    state_nxt = ONE;
                end
            end
            ONE: begin
                if (wr_done && !rd_done) begin
                    state_nxt = TWO;
                end else if (rd_done && !wr_done) begin
                    state_nxt = EMPTY;
                end
            end
            TWO: begin
                if (rd_done && !wr_done) begin
                    state_nxt = ONE;  // Write side blocked while full
                end
            end
            default: state_nxt = EMPTY;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= EMPTY;
            wr_bank <= 1'b0;
            rd_bank <= 1'b0;
        end else begin
            state <= state_nxt;
            if (wr_done) begin
                wr_bank <= !wr_bank;   // Next block goes to the other bank
            end
            if (rd_done) begin
                rd_bank <= !rd_bank;
            end
        end
    end

    assign rd_ready = (state != EMPTY);
    assign full     = (state == TWO);

endmodule

`default_nettype wire

//--- logic/scan_counter.sv
/* Read scan counter
   Counts accepted reads up to LEN-1, wraps, flags the last one */
`default_nettype none

module scan_counter #(
    parameter int LEN = 8   // 8 columns or 32 pairs
) (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        step,   // Read accepted
    output logic [4:0] cnt,
    output logic       last
);

    assign last = (cnt == 5'(LEN - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (step) begin
            if (last) begin
                cnt <= '0;           // Block finished
            end else begin
                cnt <= cnt + 5'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/transpose_buf.sv
/* Transpose buffer
   Two 8x8 banks written by rows, read back as registered columns */
`default_nettype none
`include "dct_settings.svh"

module transpose_buf (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire dct_pkg::coef1_t   d [`DCT_N-1:0],
    input  wire dct_pkg::row_idx_t d_cnt,
    input  wire                    d_valid,
    output logic                   d_hold,
    output dct_pkg::coef1_t        q [`DCT_N-1:0],
    output dct_pkg::row_idx_t      q_cnt,
    output logic                   q_valid,
    input  wire                    q_hold
);
    import dct_pkg::*;

    coef1_t     mem [0:1][0:`DCT_N-1][0:`DCT_N-1];  // Bank, row, column
    logic       wr_bank;
    logic       rd_bank;
    logic       rd_ready;
    logic       full;
    logic       wr_en;
    logic       wr_done;
    logic       rd_load;    // Column moves into the output register
    logic       rd_done;
    logic       rd_last;
    logic [4:0] rd_cnt;
    row_idx_t   col;

    // ------------------------------
    // Bank control
    // ------------------------------
    assign d_hold  = full;
    assign wr_en   = d_valid && !d_hold;
    assign wr_done = wr_en && (d_cnt == row_idx_t'(`DCT_N - 1));
    assign rd_load = rd_ready && (!q_valid || !q_hold);
    assign rd_done = rd_load && rd_last;   // Bank free once column 7 is copied out
    assign col     = rd_cnt[2:0];

    pingpong_ctrl u_pp (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_done  (wr_done),
        .rd_done  (rd_done),
        .wr_bank  (wr_bank),
        .rd_bank  (rd_bank),
        .rd_ready (rd_ready),
        .full     (full)
    );

    scan_counter #(.LEN(`DCT_N)) u_scan (
        .clk   (clk),
        .rst_n (rst_n),
        .step  (rd_load),
        .cnt   (rd_cnt),
        .last  (rd_last)
    );

    // ------------------------------
    // Storage and column read
    // ------------------------------
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int j = 0; j < `DCT_N; j++) begin
                mem[wr_bank][d_cnt][j] <= d[j];
            end
        end
        if (rd_load) begin
            for (int j = 0; j < `DCT_N; j++) begin
                q[j] <= mem[rd_bank][j][col];  // Element j is row j
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_valid <= 1'b0;
            q_cnt   <= '0;
        end else begin
            if (!q_valid || !q_hold) begin
                q_valid <= rd_ready;
            end
            if (rd_load) begin
                q_cnt <= col;     // Column index travels with the data
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/zigzag_buf.sv
/* Zigzag buffer
   Two 64-coefficient banks, read out two coefficients per cycle in JPEG zigzag order */
`default_nettype none
`include "dct_settings.svh"

module zigzag_buf (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire dct_pkg::coef_t     d [`DCT_N-1:0],
    input  wire dct_pkg::row_idx_t  d_cnt,
    input  wire                     d_valid,
    output logic                    d_hold,
    output dct_pkg::coef_t          q [1:0],
    output dct_pkg::pair_idx_t      q_cnt,
    output logic                    q_valid,
    input  wire                     q_hold
);
    import dct_pkg::*;

    localparam int PAIRS = `DCT_N * `DCT_N / 2;  // 32 reads per block

    coef_t      mem [0:1][0:`DCT_N*`DCT_N-1];    // Bank, raster position
    logic       wr_bank;
    logic       rd_bank;
    logic       rd_ready;
    logic       full;
    logic       wr_en;
    logic       wr_done;
    logic       rd_load;
    logic       rd_done;
    logic       rd_last;
    logic [4:0] rd_cnt;   // Pair index
    logic [5:0] pos0;     // Raster position of zigzag 2p
    logic [5:0] pos1;     // Raster position of zigzag 2p+1

    // ------------------------------
    // Bank control
    // ------------------------------
    assign d_hold  = full;
    assign wr_en   = d_valid && !d_hold;
    assign wr_done = wr_en && (d_cnt == row_idx_t'(`DCT_N - 1));
    assign rd_load = rd_ready && (!q_valid || !q_hold);
    assign rd_done = rd_load && rd_last;

    pingpong_ctrl u_pp (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_done  (wr_done),
        .rd_done  (rd_done),
        .wr_bank  (wr_bank),
        .rd_bank  (rd_bank),
        .rd_ready (rd_ready),
        .full     (full)
    );

    scan_counter #(.LEN(PAIRS)) u_scan (
        .clk   (clk),
        .rst_n (rst_n),
        .step  (rd_load),
        .cnt   (rd_cnt),
        .last  (rd_last)
    );

    // Zigzag lookup for the current pair
    assign pos0 = zz_order[{rd_cnt, 1'b0}];
    assign pos1 = zz_order[{rd_cnt, 1'b1}];

    // ------------------------------
    // Storage and pair read
    // ------------------------------
    // Incoming word d_cnt is horizontal frequency u, element v vertical
    // so it lands at raster v*8 + u
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int v = 0; v < `DCT_N; v++) begin
                mem[wr_bank][{3'(v), d_cnt}] <= d[v];
            end
        end
        if (rd_load) begin
            q[0] <= mem[rd_bank][pos0];
            q[1] <= mem[rd_bank][pos1];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_valid <= 1'b0;
            q_cnt   <= '0;
        end else begin
            if (!q_valid || !q_hold) begin
                q_valid <= rd_ready;
            end
            if (rd_load) begin
                q_cnt <= rd_cnt;   // Zero marks a new block
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/dct_2d.sv
/* 8x8 forward 2-D DCT
   Row pass, transpose, column pass, zigzag reorder; two coefficients out per cycle */
`default_nettype none
`include "dct_settings.svh"

module dct_2d (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire dct_pkg::sample_t   di [`DCT_N-1:0],  // One row of samples
    input  wire                     di_valid,
    output logic                    di_hold,
    input  wire dct_pkg::row_idx_t  di_cnt,           // Row within the block
    output dct_pkg::coef_t          q [1:0],          // Zigzag positions 2p, 2p+1
    output logic                    q_valid,
    input  wire                     q_hold,
    output dct_pkg::pair_idx_t      q_cnt
);
    import dct_pkg::*;

    // Row pass to transpose
    coef1_t   d0_q [`DCT_N-1:0];
    row_idx_t d0_cnt;
    logic     d0_valid;
    logic     d0_hold;

    // Transpose to column pass
    coef1_t   t_q [`DCT_N-1:0];
    row_idx_t t_cnt;
    logic     t_valid;
    logic     t_hold;

    // Column pass to zigzag
    coef_t    d1_q [`DCT_N-1:0];
    row_idx_t d1_cnt;
    logic     d1_valid;
    logic     d1_hold;

    // ------------------------------
    // Row pass, 8 to 11 bits
    // ------------------------------
    dct_1d #(.IW(`DCT_DW), .OW(`DCT_CW)) pass0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .di       (di),
        .di_valid (di_valid),
        .di_hold  (di_hold),
        .di_cnt   (di_cnt),
        .q        (d0_q),
        .q_valid  (d0_valid),
        .q_hold   (d0_hold),
        .q_cnt    (d0_cnt)
    );

    transpose_buf u_tr (
        .clk     (clk),
        .rst_n   (rst_n),
        .d       (d0_q),
        .d_cnt   (d0_cnt),
        .d_valid (d0_valid),
        .d_hold  (d0_hold),
        .q       (t_q),
        .q_cnt   (t_cnt),
        .q_valid (t_valid),
        .q_hold  (t_hold)
    );

    // ------------------------------
    // Column pass, 11 to 12 bits
    // ------------------------------
    dct_1d #(.IW(`DCT_CW), .OW(`DCT_QW)) pass1 (
        .clk      (clk),
        .rst_n    (rst_n),
        .di       (t_q),
        .di_valid (t_valid),
        .di_hold  (t_hold),
        .di_cnt   (t_cnt),
        .q        (d1_q),
        .q_valid  (d1_valid),
        .q_hold   (d1_hold),
        .q_cnt    (d1_cnt)
    );

    zigzag_buf u_zz (
        .clk     (clk),
        .rst_n   (rst_n),
        .d       (d1_q),
        .d_cnt   (d1_cnt),
        .d_valid (d1_valid),
        .d_hold  (d1_hold),
        .q       (q),
        .q_cnt   (q_cnt),
        .q_valid (q_valid),
        .q_hold  (q_hold)      // Downstream back-pressure
    );

endmodule

`default_nettype wire

//--- verif/dct_2d_chk.sv
/* Protocol checks for the 2-D DCT top level
   Output stability under hold, pair count sequence, input hold behaviour */
`default_nettype none

module dct_2d_chk (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     di_valid,
    input  wire                     di_hold,
    input  wire dct_pkg::coef_t     q [1:0],
    input  wire                     q_valid,
    input  wire                     q_hold,
    input  wire dct_pkg::pair_idx_t q_cnt
);
    timeunit 1ns;
    timeprecision 100ps;
    import dct_pkg::*;

    pair_idx_t last_cnt;   // q_cnt of the previous transfer
    logic      seen;       // At least one transfer since reset

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seen     <= 1'b0;
            last_cnt <= '0;
        end else if (q_valid && !q_hold) begin
            seen     <= 1'b1;
            last_cnt <= q_cnt;
        end
    end

    // ------------------------------
    // Output side
    // ------------------------------
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        q_valid && q_hold |=> q_valid && $stable(q_cnt) && $stable(q[0]) && $stable(q[1]))
        else $error("output changed while held");

    a_first_pair: assert property (@(posedge clk) disable iff (!rst_n)
        q_valid && !q_hold && !seen |-> q_cnt == '0)
        else $error("first pair after reset is not pair 0");

    a_cnt_step: assert property (@(posedge clk) disable iff (!rst_n)
        q_valid && !q_hold && seen |-> q_cnt == pair_idx_t'(last_cnt + 5'd1))
        else $error("q_cnt did not step by one between transfers");

    // Hold may only rise over a row that was taken
    a_no_drop: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(di_hold) |-> $past(di_valid))
        else $error("di_hold rose without a captured row");

endmodule

`default_nettype wire

//--- verif/dct_2d_tb.sv
/* Testbench for the 8x8 forward 2-D DCT
   Directed tests checked against a model of both passes and the zigzag order */
`default_nettype none
`include "dct_settings.svh"

module dct_2d_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import dct_pkg::*;

    localparam logic [31:0] SEED = 32'hb931_1514;
    localparam int NBLK    = 28;                 // 2 constant, 6 impulse, 10 + 10 random
    localparam int TIMEOUT = NBLK * 200 + 200;   // Cycles
    localparam int IMP_POS [0:5] = '{0, 1, 8, 19, 46, 63};  // Raster positions

    logic        clk = 1'b0;
    logic        rst_n;
    sample_t     di [`DCT_N-1:0];
    logic        di_valid;
    logic        di_hold;
    row_idx_t    di_cnt;
    coef_t       q [1:0];
    logic        q_valid;
    logic        q_hold = 1'b0;
    pair_idx_t   q_cnt;

    sample_t     blk_mem [0:9][0:63];   // Stimulus blocks in raster order
    coef_t       exp_q [$];             // Expected coefficients in zigzag order
    int          rx_idx      = 0;       // Next entry of exp_q to see
    pair_idx_t   rx_pair     = '0;
    logic [31:0] data_lfsr   = SEED;    // Samples and input gaps
    logic [31:0] hold_lfsr   = SEED;    // Output hold pattern
    logic        hold_rand   = 1'b0;
    string       test_name   = "reset";
    int          main_errors = 0;
    int          main_checks = 0;
    int          mon_errors  = 0;
    int          mon_checks  = 0;
    int          err_start   = 0;
    int          tests_done  = 0;
    int          cycles      = 0;

    dct_2d dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .di       (di),
        .di_valid (di_valid),
        .di_hold  (di_hold),
        .di_cnt   (di_cnt),
        .q        (q),
        .q_valid  (q_valid),
        .q_hold   (q_hold),
        .q_cnt    (q_cnt)
    );

    bind dct_2d dct_2d_chk chk_i (
        .clk(clk), .rst_n(rst_n), .di_valid(di_valid), .di_hold(di_hold),
        .q(q), .q_valid(q_valid), .q_hold(q_hold), .q_cnt(q_cnt)
    );

    always #20 clk = ~clk;   // 40 ns period

    // ------------------------------
    // Random source and model
    // ------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32, 22, 2, 1
    endfunction

    function automatic logic draw_bit();
        data_lfsr = lfsr_next(data_lfsr);
        return data_lfsr[0];
    endfunction

    function automatic sample_t draw_sample();
        sample_t s;
        s = '0;
        for (int i = 0; i < `DCT_DW; i++) begin
            s = {s[`DCT_DW-2:0], draw_bit()};   // One step per bit
        end
        return s;
    endfunction

    // Add half, shift down, clip to a signed word of the given width
    function automatic int round_sat(input int sum, input int width);
        int r;
        int hi;
        r  = (sum + (1 << (`DCT_FRAC - 1))) >>> `DCT_FRAC;
        hi = (1 << (width - 1)) - 1;
        if (r > hi) begin
            r = hi;
        end else if (r < -hi - 1) begin
            r = -hi - 1;
        end
        return r;
    endfunction

    task automatic push_model(input int b);
        int rows [0:7][0:7];   // Row pass results by [row][u]
        int coef [0:7][0:7];   // Column pass results by [v][u]
        int acc;
        int pos;
        for (int r = 0; r < 8; r++) begin
            for (int k = 0; k < 8; k++) begin
                acc = 0;
                for (int n = 0; n < 8; n++) begin
                    acc += int'(dct_cos[k][n]) * int'(blk_mem[b][r * 8 + n]);
                end
                rows[r][k] = round_sat(acc, `DCT_CW);
            end
        end
        for (int u = 0; u < 8; u++) begin
            for (int v = 0; v < 8; v++) begin
                acc = 0;
                for (int j = 0; j < 8; j++) begin
                    acc += int'(dct_cos[v][j]) * rows[j][u];   // Down column u
                end
                coef[v][u] = round_sat(acc, `DCT_QW);
            end
        end
        for (int i = 0; i < 64; i++) begin
            pos = int'(zz_order[i]);
            exp_q.push_back(coef_t'(coef[pos / 8][pos % 8]));
        end
    endtask

    // ------------------------------
    // Compare tasks and output monitor
    // ------------------------------
    task automatic check_coef(input string what, input coef_t exp, input coef_t act);
        mon_checks++;
        if (act !== exp) begin
            mon_errors++;
            $display("mismatch %s %s expected %0d actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic check_pair_idx(input pair_idx_t exp, input pair_idx_t act);
        mon_checks++;
        if (act !== exp) begin
            mon_errors++;
            $display("mismatch %s q_cnt expected %0d actual %0d", test_name, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        main_checks++;
        if (act !== exp) begin
            main_errors++;
            $display("mismatch %s %s expected %0b actual %0b", test_name, what, exp, act);
        end
    endtask

    always @(posedge clk) begin
        if (rst_n && q_valid && !q_hold) begin   // Transfer on this edge
            if (rx_idx + 2 > exp_q.size()) begin
                mon_errors++;
                $display("%s: pair %0d came out with no coefficient expected", test_name, q_cnt);
            end else begin
                check_pair_idx(rx_pair, q_cnt);
                check_coef("q[0]", exp_q[rx_idx], q[0]);
                check_coef("q[1]", exp_q[rx_idx + 1], q[1]);
                rx_idx += 2;
            end
            rx_pair++;
        end
    end

    always @(negedge clk) begin
        if (hold_rand) begin
            hold_lfsr = lfsr_next(hold_lfsr);
            q_hold    = hold_lfsr[0];   // Held about half the time
        end else begin
            q_hold = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("timeout after %0d cycles, %0d coefficients never came out",
                     cycles, exp_q.size() - rx_idx);
            $display("sim failed");
            $finish;
        end
    end

    // ------------------------------
    // Stimulus helpers
    // ------------------------------
    task automatic send_block(input int b, input logic gaps);
        for (int r = 0; r < 8; r++) begin
            @(negedge clk);
            if (gaps && draw_bit()) begin
                di_valid = 1'b0;                  // One idle cycle
                @(negedge clk);
            end
            for (int n = 0; n < 8; n++) begin
                di[n] = blk_mem[b][r * 8 + n];
            end
            di_cnt   = row_idx_t'(r);
            di_valid = 1'b1;
            while (di_hold) begin
                @(negedge clk);                   // Keep the row until taken
            end
        end
    endtask

    task automatic end_input_and_drain();
        @(negedge clk);
        di_valid = 1'b0;
        while (rx_idx < exp_q.size()) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);                // Room for a stray extra pair
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_start = main_errors + mon_errors;
    endtask

    task automatic end_test();
        int n;
        n = main_errors + mon_errors - err_start;
        tests_done++;
        if (n == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, n);
        end
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic test_reset();
        start_test("reset");
        check_flag("q_valid", 1'b0, q_valid);
        check_flag("di_hold", 1'b0, di_hold);
        end_test();
    endtask

    task automatic test_const();
        start_test("const_block");
        for (int i = 0; i < 64; i++) begin
            blk_mem[0][i] = sample_t'(100);
            blk_mem[1][i] = sample_t'(-128);    // Most negative input
        end
        push_model(0);
        push_model(1);
        send_block(0, 1'b0);
        send_block(1, 1'b0);
        end_input_and_drain();
        end_test();
    endtask

    task automatic test_impulse();
        start_test("impulse");
        for (int p = 0; p < 6; p++) begin
            for (int i = 0; i < 64; i++) begin
                blk_mem[0][i] = '0;
            end
            blk_mem[0][IMP_POS[p]] = (p % 2 == 0) ? sample_t'(127) : sample_t'(-100);
            push_model(0);
            send_block(0, 1'b0);
            end_input_and_drain();
        end
        end_test();
    endtask

    task automatic test_stream();
        start_test("stream");
        for (int b = 0; b < 10; b++) begin
            for (int i = 0; i < 64; i++) begin
                blk_mem[b][i] = draw_sample();
            end
            push_model(b);
        end
        for (int b = 0; b < 10; b++) begin
            send_block(b, 1'b0);                  // di_valid stays high
        end
        end_input_and_drain();
        end_test();
    endtask

    // Same blocks as the stream test with output holds and input gaps
    task automatic test_backpressure();
        start_test("backpressure");
        @(posedge clk);
        hold_rand = 1'b1;
        for (int b = 0; b < 10; b++) begin
            push_model(b);
        end
        for (int b = 0; b < 10; b++) begin
            send_block(b, 1'b1);
        end
        end_input_and_drain();
        @(posedge clk);
        hold_rand = 1'b0;
        end_test();
    endtask

    initial begin
        rst_n    = 1'b0;
        di_valid = 1'b0;
        di_cnt   = '0;
        for (int n = 0; n < `DCT_N; n++) begin
            di[n] = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset();
        test_const();
        test_impulse();
        test_stream();
        test_backpressure();

        $display("%0d tests, %0d checks, %0d errors",
                 tests_done, main_checks + mon_checks, main_errors + mon_errors);
        if (main_errors + mon_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+logic
logic/dct_pkg.sv
logic/dct_1d.sv
logic/pingpong_ctrl.sv
logic/scan_counter.sv
logic/transpose_buf.sv
logic/zigzag_buf.sv
logic/dct_2d.sv
verif/dct_2d_chk.sv
verif/dct_2d_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the 2-D DCT testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module dct_2d_tb \
    -f files.f \
    -o dct_2d_sim

./obj_dir/dct_2d_sim | tee sim.log

# The testbench prints its verdict on a line of its own
if grep -qx "sim passed" sim.log; then
    echo "run_sim: PASS"
else
    echo "run_sim: FAIL"
    exit 1
fi
